/* verilog/dcache_config.svh */
`default_nettype none

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Processor word
`define DC_WORD_BITS    32

// Line geometry
`define DC_LINE_WORDS   8
`define DC_LINE_BITS    256
`define DC_OFFSET_BITS  5     // Byte offset within a line

// Small index on purpose so lines collide often
`define DC_INDEX_BITS   4
`define DC_TAG_BITS     (32 - `DC_INDEX_BITS - `DC_OFFSET_BITS)

// One tag write per line after reset
`define DC_SWEEP_LINES  (1 << `DC_INDEX_BITS)

`endif

`default_nettype wire

/* verilog/dcache_store_pkg.sv */
`include "dcache_config.svh"
`default_nettype none

package dcache_store_pkg;

  // One full cache line, word 0 in the low bits
  typedef logic [`DC_LINE_BITS-1:0] line_t;

  typedef logic [`DC_INDEX_BITS-1:0] index_t;   // Line select

  typedef logic [2:0] word_sel_t;               // Word within a line

  typedef logic [`DC_TAG_BITS-1:0] page_t;      // Upper address bits

  // Tag RAM entry, D,V,page as in the old tag layout
  typedef struct packed {
    logic  dirty;
    logic  valid;
    page_t page;
  } tag_entry_t;

endpackage

`default_nettype wire

/* verilog/dcache_bus_pkg.sv */
`default_nettype none

package dcache_bus_pkg;

  // Processor access size
  typedef enum logic [1:0] {
    ACC_BYTE = 2'b00,
    ACC_HALF = 2'b01,
    ACC_WORD = 2'b10,
    ACC_RSVD = 2'b11   // Old double word code, never issued
  } acc_size_e;

  typedef logic [3:0] lane_mask_t;   // Byte lanes of one word, bit 0 is lane 0

endpackage

`default_nettype wire

/* verilog/dc_ram2p.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dc_ram2p import dcache_store_pkg::*;
#(
  parameter type payload_t = line_t
)
(
  input  wire logic     nGCLK,
  input  wire logic     wr_en,
  input  wire index_t   wr_index,
  input  wire payload_t wr_data,
  input  wire index_t   rd_index,
  output payload_t      rd_data
);

  payload_t mem [`DC_SWEEP_LINES];   // One entry per line

  always_ff @(posedge nGCLK)
  begin
    if (wr_en)
      mem[wr_index] <= wr_data;
    // Same-index read sees the new data
    if (wr_en && (wr_index == rd_index))
      rd_data <= wr_data;
    else
      rd_data <= mem[rd_index];
  end

  a_wr_index_known: assert property (@(posedge nGCLK) wr_en |-> !$isunknown(wr_index))
    else $error("dc_ram2p write with unknown index");

endmodule

`default_nettype wire

/* verilog/dc_req_latch.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dc_req_latch import dcache_store_pkg::*; import dcache_bus_pkg::*;
(
  input  wire logic                     nGCLK,
  input  wire logic                     nRESET,
  input  wire logic                     req,
  input  wire logic                     wr,
  input  wire acc_size_e                size,
  input  wire logic [`DC_WORD_BITS-1:0] addr,
  input  wire logic [`DC_WORD_BITS-1:0] wdata,
  input  wire logic                     hold,
  input  wire logic                     sweeping,
  input  wire index_t                   sweep_index,
  output logic                          acc_valid,
  output logic                          acc_wr,
  output acc_size_e                     acc_size,
  output logic [`DC_WORD_BITS-1:0]      acc_addr,
  output logic [`DC_WORD_BITS-1:0]      acc_wdata,
  output index_t                        rd_index
);

  // Control bits, frozen while the miss is serviced
  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      acc_valid <= 1'b0;
      acc_wr    <= 1'b0;
    end
    else if (!hold)
    begin
      acc_valid <= req;        // Drops when no request this edge
      acc_wr    <= req & wr;
    end
  end

  // Access payload
  always_ff @(posedge nGCLK)
  begin
    if (!hold && req)
    begin
      acc_size  <= size;
      acc_addr  <= addr;
      acc_wdata <= wdata;
    end
  end

  // RAM read line select
  always_comb
  begin
    if (sweeping)
      rd_index = sweep_index;
    else if (hold)
      rd_index = acc_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];   // Stalled, keep own line
    else
      rd_index = addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
  end

  a_no_rsvd_size: assert property (@(posedge nGCLK) disable iff (!nRESET)
    (req && !hold) |-> (size != ACC_RSVD))
    else $error("dc_req_latch sampled reserved access size");

endmodule

`default_nettype wire

/* verilog/dc_miss_ctrl.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dc_miss_ctrl import dcache_store_pkg::*;
(
  input  wire logic                     nGCLK,
  input  wire logic                     nRESET,
  input  wire logic                     acc_valid,
  input  wire logic                     acc_wr,
  input  wire logic [`DC_WORD_BITS-1:0] acc_addr,
  input  wire tag_entry_t               tag_rd,
  input  wire logic                     mem_valid,
  input  wire logic                     mem_grant,
  output logic                          hold,
  output logic                          stall,
  output logic                          initializing,
  output logic                          sweeping,
  output index_t                        sweep_index,
  output logic                          line_wr_en,
  output logic                          tag_wr_en,
  output tag_entry_t                    tag_wr_data,
  output word_sel_t                     word_cnt,
  output logic                          fill_word,
  output logic                          mem_req,
  output logic                          mem_wb,
  output page_t                         victim_page
);

  typedef enum logic [1:0] {ST_SWEEP, ST_IDLE, ST_WB, ST_FILL} state_e;

  state_e state, state_nxt;
  index_t sweep_cnt;
  page_t  acc_page;
  index_t acc_index;
  logic   hit, miss, store_hit;
  logic   wb_last, fill_last;

  assign acc_page  = acc_addr[`DC_WORD_BITS-1 -: `DC_TAG_BITS];
  assign acc_index = acc_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];

  // Hit test on the tag read for the latched access
  assign hit       = acc_valid & tag_rd.valid & (tag_rd.page == acc_page);
  assign miss      = (state == ST_IDLE) & acc_valid & ~hit;
  assign store_hit = (state == ST_IDLE) & hit & acc_wr;

  // Eighth word of a burst
  assign wb_last   = (state == ST_WB) & mem_grant &
                     (word_cnt == word_sel_t'(`DC_LINE_WORDS-1));
  assign fill_last = (state == ST_FILL) & mem_valid &
                     (word_cnt == word_sel_t'(`DC_LINE_WORDS-1));

  assign sweeping     = (state == ST_SWEEP);
  assign initializing = sweeping;
  assign stall        = miss | (state == ST_WB) | (state == ST_FILL);
  assign hold         = stall | sweeping;
  assign mem_req      = (state == ST_WB) | (state == ST_FILL);
  assign mem_wb       = (state == ST_WB);
  assign fill_word    = (state == ST_FILL) & mem_valid;
  assign victim_page  = tag_rd.page;   // Valid while the victim tag is unchanged

  assign line_wr_en = fill_word | store_hit;
  assign tag_wr_en  = sweeping | wb_last | fill_last | store_hit;

  // Write line for both RAMs, the access line outside the sweep
  assign sweep_index = sweeping ? sweep_cnt : acc_index;

  always_comb
  begin
    tag_wr_data.dirty = 1'b1;       // Store hit
    tag_wr_data.valid = 1'b1;
    tag_wr_data.page  = acc_page;
    if (sweeping)
    begin
      tag_wr_data = '0;
    end
    else if (wb_last)
    begin
      tag_wr_data.dirty = 1'b0;     // Victim now clean, invalid
      tag_wr_data.valid = 1'b0;
      tag_wr_data.page  = tag_rd.page;
    end
    else if (fill_last)
      tag_wr_data.dirty = 1'b0;     // Fresh line, clean
  end

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      ST_SWEEP:
        if (sweep_cnt == index_t'(`DC_SWEEP_LINES-1))
          state_nxt = ST_IDLE;
      ST_IDLE:
        if (miss)
          state_nxt = (tag_rd.valid & tag_rd.dirty) ? ST_WB : ST_FILL;
      ST_WB:
        if (wb_last)
          state_nxt = ST_FILL;
      ST_FILL:
        if (fill_last)
          state_nxt = ST_IDLE;   // Access replays as a hit
    endcase
  end

  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      state     <= ST_SWEEP;
      sweep_cnt <= '0;
      word_cnt  <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (sweeping)
        sweep_cnt <= sweep_cnt + 1'b1;
      if (((state == ST_WB) & mem_grant) | fill_word)
        word_cnt <= word_cnt + 1'b1;   // Wraps to 0 after a burst
    end
  end

  a_no_acc_in_sweep: assert property (@(posedge nGCLK) disable iff (!nRESET)
    initializing |-> !acc_valid)
    else $error("dc_miss_ctrl access latched during tag sweep");

  a_burst_from_word0: assert property (@(posedge nGCLK) disable iff (!nRESET)
    ($rose(mem_req) || $fell(mem_wb)) |-> (word_cnt == '0))
    else $error("dc_miss_ctrl burst does not start at word 0");

endmodule

`default_nettype wire

/* verilog/dc_line_merge.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dc_line_merge import dcache_store_pkg::*; import dcache_bus_pkg::*;
(
  input  wire line_t                    line_rd,
  input  wire acc_size_e                acc_size,
  input  wire logic [`DC_WORD_BITS-1:0] acc_addr,
  input  wire logic [`DC_WORD_BITS-1:0] acc_wdata,
  input  wire logic                     big_end,
  input  wire logic                     fill_word,
  input  wire word_sel_t                word_cnt,
  input  wire logic [`DC_WORD_BITS-1:0] mem_rdata,
  output line_t                         line_wr_data
);

  word_sel_t                wsel;
  lane_mask_t               lanes;
  logic [1:0]               byte_lane;
  logic [`DC_WORD_BITS-1:0] old_word;
  logic [`DC_WORD_BITS-1:0] new_word;

  always_comb
  begin
    // Big-endian flips the lane number, 3 - addr[1:0]
    byte_lane = acc_addr[1:0] ^ {2{big_end}};

    case (acc_size)
      ACC_BYTE: lanes = lane_mask_t'(4'b0001 << byte_lane);
      ACC_HALF: lanes = (acc_addr[1] == big_end) ? 4'b0011 : 4'b1100;
      default:  lanes = 4'b1111;   // Word
    endcase

    // Fill inserts at the burst count, stores at the addressed word
    wsel     = fill_word ? word_cnt : acc_addr[`DC_OFFSET_BITS-1:2];
    old_word = line_rd[wsel*`DC_WORD_BITS +: `DC_WORD_BITS];

    if (fill_word)
      new_word = mem_rdata;
    else
    begin
      for (int i = 0; i < 4; i++)
        new_word[8*i +: 8] = lanes[i] ? acc_wdata[8*i +: 8] : old_word[8*i +: 8];
    end

    line_wr_data = line_rd;
    line_wr_data[wsel*`DC_WORD_BITS +: `DC_WORD_BITS] = new_word;
  end

endmodule

`default_nettype wire

/* verilog/dc_bus_drive.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dc_bus_drive import dcache_store_pkg::*;
(
  input  wire logic                     nGCLK,
  input  wire logic                     nRESET,
  input  wire line_t                    line_rd,
  input  wire logic [`DC_WORD_BITS-1:0] acc_addr,
  input  wire logic                     acc_valid,
  input  wire logic                     acc_wr,
  input  wire logic                     stall,
  input  wire word_sel_t                word_cnt,
  input  wire logic                     mem_wb,
  input  wire page_t                    victim_page,
  output logic [`DC_WORD_BITS-1:0]      rdata,
  output logic                          rd_valid,
  output logic [`DC_WORD_BITS-1:0]      mem_addr,
  output logic [`DC_WORD_BITS-1:0]      mem_wdata
);

  page_t  victim_q;   // Victim page held over the write-back
  index_t acc_index;

  // Captured in the miss cycle, frozen once write-back starts
  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
      victim_q <= '0;
    else if (!mem_wb)
      victim_q <= victim_page;
  end

  assign acc_index = acc_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];

  // Valid, unstalled access in idle is always a hit
  assign rd_valid  = acc_valid & ~acc_wr & ~stall;
  assign rdata     = line_rd[acc_addr[`DC_OFFSET_BITS-1:2]*`DC_WORD_BITS +: `DC_WORD_BITS];
  assign mem_wdata = line_rd[word_cnt*`DC_WORD_BITS +: `DC_WORD_BITS];

  // Line address, zero byte offset
  assign mem_addr  = {(mem_wb ? victim_q : acc_addr[`DC_WORD_BITS-1 -: `DC_TAG_BITS]),
                      acc_index, {`DC_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_store_pkg::*; import dcache_bus_pkg::*;
(
  input  wire logic                     nGCLK,
  input  wire logic                     nRESET,
  input  wire logic                     req,
  input  wire logic                     wr,
  input  wire acc_size_e                size,
  input  wire logic [`DC_WORD_BITS-1:0] addr,
  input  wire logic [`DC_WORD_BITS-1:0] wdata,
  input  wire logic                     big_end,
  output logic [`DC_WORD_BITS-1:0]      rdata,
  output logic                          rd_valid,
  output logic                          stall,
  output logic                          initializing,
  output logic                          mem_req,
  output logic                          mem_wb,
  output logic [`DC_WORD_BITS-1:0]      mem_addr,
  output logic [`DC_WORD_BITS-1:0]      mem_wdata,
  input  wire logic [`DC_WORD_BITS-1:0] mem_rdata,
  input  wire logic                     mem_valid,
  input  wire logic                     mem_grant
);

  logic                     acc_valid, acc_wr;
  acc_size_e                acc_size;
  logic [`DC_WORD_BITS-1:0] acc_addr, acc_wdata;
  index_t                   rd_index, sweep_index;
  logic                     hold, sweeping;
  logic                     line_wr_en, tag_wr_en, fill_word;
  line_t                    line_rd, line_wr_data;
  tag_entry_t               tag_rd, tag_wr_data;
  word_sel_t                word_cnt;
  page_t                    victim_page;

  dc_req_latch u_req_latch (.*);   // Processor side

  dc_miss_ctrl u_miss_ctrl (.*);

  dc_line_merge u_line_merge (.*);

  dc_bus_drive u_bus_drive (.*);

  // Data lines
  dc_ram2p #(.payload_t(line_t)) u_line_ram (
    .nGCLK(nGCLK), .wr_en(line_wr_en), .wr_index(sweep_index),
    .wr_data(line_wr_data), .rd_index(rd_index), .rd_data(line_rd));

  // D,V,page per line
  dc_ram2p #(.payload_t(tag_entry_t)) u_tag_ram (
    .nGCLK(nGCLK), .wr_en(tag_wr_en), .wr_index(sweep_index),
    .wr_data(tag_wr_data), .rd_index(rd_index), .rd_data(tag_rd));

endmodule

`default_nettype wire

/* verification/dcache_tb_model.svh */
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

// Test window of four pages
localparam int PAGE_BITS = `DC_INDEX_BITS + `DC_OFFSET_BITS;   // Byte address bits under the tag
localparam int NUM_PAGES = 4;
localparam int MEM_WORDS = (NUM_PAGES << PAGE_BITS) / 4;

logic [31:0] ref_mem [MEM_WORDS];           // Latest value of every word
logic [31:0] ext_mem [MEM_WORDS];           // Main memory behind the cache
logic        tag_valid [`DC_SWEEP_LINES];   // Own view of the tag RAM
logic        tag_dirty [`DC_SWEEP_LINES];
int          tag_page [`DC_SWEEP_LINES];
int          errors = 0;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Start contents, every address bit takes part
function automatic logic [31:0] init_word(input int wi);
  logic [31:0] a;
  a = 32'(wi) << 2;
  return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
endfunction

// Word after a store, by the endian lane rules
function automatic logic [31:0] merge_store(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input acc_size_e sz, input logic [1:0] lo,
                                            input logic be);
  logic [3:0]  mask;
  logic [31:0] bits;
  int          lane;
  lane = be ? 3 - int'(lo) : int'(lo);     // Big-endian counts lanes from the top
  if (sz == ACC_BYTE)
    mask = 4'b0001 << lane;
  else if (sz == ACC_HALF)
    mask = (lo[1] == be) ? 4'b0011 : 4'b1100;
  else
    mask = 4'b1111;
  bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  return (old_w & ~bits) | (new_w & bits);
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
  begin
    errors++;
    $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic model_reset;
  for (int i = 0; i < MEM_WORDS; i++)
  begin
    ref_mem[i] = init_word(i);
    ext_mem[i] = init_word(i);
  end
  for (int i = 0; i < `DC_SWEEP_LINES; i++)
  begin
    tag_valid[i] = 1'b0;   // Sweep leaves all lines invalid
    tag_dirty[i] = 1'b0;
    tag_page[i]  = 0;
  end
endtask

`endif

/* verification/dcache_tb.sv */
`include "dcache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_bus_pkg::*;
();

  localparam logic [31:0] SEED = 32'h728b;
  localparam int N_RANDOM       = 400;
  localparam int N_DIRECTED     = 40;
  localparam int MAX_ACC_CYCLES = 40;   // Write-back and fill with gaps
  // Flush adds at most one access per line
  localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED + `DC_SWEEP_LINES) * MAX_ACC_CYCLES
                                  + 2 * `DC_SWEEP_LINES;

  logic        nGCLK;
  logic        nRESET;
  logic        req;
  logic        wr;
  acc_size_e   size;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        big_end;
  logic [31:0] rdata;
  logic        rd_valid;
  logic        stall;
  logic        initializing;
  logic        mem_req;
  logic        mem_wb;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_valid;
  logic        mem_grant;

  `include "dcache_tb_model.svh"

  // Access in flight
  logic        pend;
  logic        pend_first;   // No cycle seen yet
  logic        pend_wr;
  logic        pend_miss;
  logic        pend_dirty;
  logic [31:0] pend_exp;
  logic [31:0] exp_wb_addr;
  logic [31:0] exp_fill_addr;
  int          wb_base;
  int          fill_base;
  int          wb_seen;      // Words granted in write-back
  int          fill_seen;    // Words returned in fill
  logic [31:0] stim_rng;
  logic [31:0] mem_rng;
  int          cycles;

  dcache_top UUT (.*);

  initial
  begin
    nGCLK = 1'b0;
    forever #2 nGCLK = ~nGCLK;
  end

  function automatic logic [31:0] make_addr(input int page, input int idx, input int word,
                                            input int boff);
    return 32'((page << PAGE_BITS) | (idx << `DC_OFFSET_BITS) | (word << 2) | boff);
  endfunction

  // Model update for a request that the next edge samples
  task automatic predict(input logic w, input acc_size_e sz, input logic [31:0] a,
                         input logic [31:0] d, input logic be);
    int idx;
    int page;
    int wi;
    idx        = int'(a[`DC_OFFSET_BITS +: `DC_INDEX_BITS]);
    page       = int'(a >> PAGE_BITS);
    wi         = int'(a >> 2) % MEM_WORDS;
    pend_miss  = !(tag_valid[idx] && tag_page[idx] == page);
    pend_dirty = pend_miss && tag_valid[idx] && tag_dirty[idx];
    wb_base    = ((tag_page[idx] << PAGE_BITS) | (idx << `DC_OFFSET_BITS)) >> 2;
    fill_base  = ((page << PAGE_BITS) | (idx << `DC_OFFSET_BITS)) >> 2;
    exp_wb_addr   = 32'(wb_base << 2);
    exp_fill_addr = 32'(fill_base << 2);
    if (pend_miss)
    begin
      tag_valid[idx] = 1'b1;   // Refilled clean
      tag_page[idx]  = page;
      tag_dirty[idx] = 1'b0;
    end
    if (w)
    begin
      ref_mem[wi]    = merge_store(ref_mem[wi], d, sz, a[1:0], be);
      tag_dirty[idx] = 1'b1;
    end
    else
      pend_exp = ref_mem[wi];
    pend_wr    = w;
    pend       = 1'b1;
    pend_first = 1'b1;
    wb_seen    = 0;
    fill_seen  = 0;
  endtask

  // Once per falling edge, outputs are stable here
  task automatic observe;
    if (pend)
    begin
      if (pend_first)
      begin
        check("stall", 32'(stall), 32'(pend_miss));   // Miss shows one cycle after sampling
        pend_first = 1'b0;
      end
      if (!stall)
      begin
        check("rd_valid", 32'(rd_valid), 32'(!pend_wr));
        if (!pend_wr)
          check("rdata", rdata, pend_exp);
        check("write-back words", wb_seen, pend_dirty ? `DC_LINE_WORDS : 0);
        check("fill words", fill_seen, pend_miss ? `DC_LINE_WORDS : 0);
        pend = 1'b0;
      end
    end
    else
      check("rd_valid", 32'(rd_valid), 32'd0);
  endtask

  // Entered and left on a falling edge
  task automatic access(input logic w, input acc_size_e sz, input logic [31:0] a,
                        input logic [31:0] d, input logic be);
    if (be !== big_end)
      drain();   // A store still in flight merges with the live big_end
    req     = 1'b1;
    wr      = w;
    size    = sz;
    addr    = a;
    wdata   = d;
    big_end = be;
    observe();
    while (stall || initializing)   // Inputs held while stalled
    begin
      @(negedge nGCLK);
      observe();
    end
    predict(w, sz, a, d, be);
    @(negedge nGCLK);
    req = 1'b0;
  endtask

  task automatic drain;
    req = 1'b0;
    observe();
    while (pend)
    begin
      @(negedge nGCLK);
      observe();
    end
    @(negedge nGCLK);
  endtask

  task automatic sweep_check;
    int cnt;
    cnt = 0;
    check("stall", 32'(stall), 32'd0);
    check("mem_req", 32'(mem_req), 32'd0);
    check("mem_wb", 32'(mem_wb), 32'd0);
    while (initializing)
    begin
      cnt++;
      @(negedge nGCLK);
    end
    check("initializing cycles", cnt, `DC_SWEEP_LINES);
  endtask

  task automatic hit_reads;
    access(1'b0, ACC_WORD, make_addr(0, 2, 3, 0), 32'd0, 1'b0);   // Miss, line filled
    access(1'b0, ACC_WORD, make_addr(0, 2, 3, 0), 32'd0, 1'b0);   // Hits from here on
    access(1'b0, ACC_WORD, make_addr(0, 2, 0, 0), 32'd0, 1'b0);
    access(1'b0, ACC_WORD, make_addr(0, 2, 7, 0), 32'd0, 1'b0);
    drain();
  endtask

  task automatic endian_stores;
    int step;
    for (int be = 0; be < 2; be++)
      for (int s = 0; s < 3; s++)
      begin
        step = (s == 0) ? 1 : (s == 1) ? 2 : 4;
        for (int k = 0; k < 4; k += step)
        begin
          stim_rng = xorshift32(stim_rng);
          access(1'b1, acc_size_e'(s), make_addr(1, 5 + be, 4 * s / 2 + k, k), stim_rng,
                 1'(be));
          access(1'b0, ACC_WORD, make_addr(1, 5 + be, 4 * s / 2 + k, 0), 32'd0, 1'(be));
        end
      end
    drain();
  endtask

  task automatic evictions;
    stim_rng = xorshift32(stim_rng);
    access(1'b1, ACC_WORD, make_addr(0, 9, 1, 0), stim_rng, 1'b0);   // Line now dirty
    access(1'b0, ACC_WORD, make_addr(2, 9, 1, 0), 32'd0, 1'b0);      // Dirty victim
    access(1'b0, ACC_WORD, make_addr(0, 9, 1, 0), 32'd0, 1'b0);      // Clean victim
    drain();
  endtask

  task automatic random_mix;
    logic [31:0] r;
    acc_size_e   sz;
    int          boff;
    repeat (N_RANDOM)
    begin
      stim_rng = xorshift32(stim_rng);
      r        = stim_rng;
      stim_rng = xorshift32(stim_rng);
      sz       = (r[10:9] == 2'b11) ? ACC_WORD : acc_size_e'(r[10:9]);
      boff     = (sz == ACC_BYTE) ? int'(r[14:13]) : (sz == ACC_HALF) ? 2 * int'(r[14]) : 0;
      if (r[11])
        access(1'b1, sz, make_addr(int'(r[1:0]), int'(r[2 +: `DC_INDEX_BITS]),
               int'(r[8:6]), boff), stim_rng, r[12]);
      else
        access(1'b0, ACC_WORD, make_addr(int'(r[1:0]), int'(r[2 +: `DC_INDEX_BITS]),
               int'(r[8:6]), 0), 32'd0, r[12]);
      if (r[16:15] == 2'b00)
      begin
        observe();          // Idle cycle
        @(negedge nGCLK);
      end
    end
    drain();
  endtask

  // Conflict read on every dirty line
  task automatic flush_dirty;
    for (int i = 0; i < `DC_SWEEP_LINES; i++)
      if (tag_valid[i] && tag_dirty[i])
        access(1'b0, ACC_WORD, make_addr((tag_page[i] + 1) % NUM_PAGES, i, 0, 0), 32'd0, 1'b0);
    drain();
  endtask

  task automatic compare_memory;
    for (int i = 0; i < MEM_WORDS; i++)
      check($sformatf("memory word %0d", i), ext_mem[i], ref_mem[i]);
  endtask

  // Memory responder with random gaps
  initial
  begin
    mem_valid = 1'b0;
    mem_grant = 1'b0;
    mem_rdata = '0;
    mem_rng   = ~SEED;   // Own stream, apart from the stimulus
    forever
    begin
      @(negedge nGCLK);
      mem_rng   = xorshift32(mem_rng);
      mem_valid = 1'b0;
      mem_grant = 1'b0;
      if (mem_req && mem_wb)
      begin
        check("mem_addr", mem_addr, exp_wb_addr);
        if (mem_rng[1:0] != 2'b00 && wb_seen < `DC_LINE_WORDS)
        begin
          mem_grant = 1'b1;   // Word taken at the next edge
          check("mem_wdata", mem_wdata, ref_mem[wb_base + wb_seen]);
          ext_mem[wb_base + wb_seen] = mem_wdata;
          wb_seen++;
        end
      end
      else if (mem_req)
      begin
        check("mem_addr", mem_addr, exp_fill_addr);
        if (mem_rng[1:0] != 2'b00 && fill_seen < `DC_LINE_WORDS)
        begin
          mem_valid = 1'b1;
          mem_rdata = ext_mem[fill_base + fill_seen];
          fill_seen++;
        end
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge nGCLK);
      cycles++;
    end
    $display("Timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    nRESET   = 1'b0;
    req      = 1'b0;
    wr       = 1'b0;
    size     = ACC_WORD;
    addr     = '0;
    wdata    = '0;
    big_end  = 1'b0;
    pend     = 1'b0;
    pend_first = 1'b0;
    stim_rng = SEED;
    model_reset();
    repeat (4) @(posedge nGCLK);
    @(negedge nGCLK);
    nRESET = 1'b1;
    sweep_check();
    hit_reads();
    endian_stores();
    evictions();
    random_mix();
    flush_dirty();
    compare_memory();
    $display("Run complete after %0d cycles, %0d errors", cycles, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
+incdir+verification
verilog/dcache_store_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dc_ram2p.sv
verilog/dc_req_latch.sv
verilog/dc_miss_ctrl.sv
verilog/dc_line_merge.sv
verilog/dc_bus_drive.sv
verilog/dcache_top.sv
verification/dcache_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = dcache_tb
FLIST = files.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
